/* common/afifo_pkg.sv */
package afifo_pkg;

   // port widths, write side is the wide one
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // storage depth counted in read units (bytes)
   localparam int ADDR_W = 6;

   // width ratio between the two ports
   localparam int RATIO   = W_DATA_W / R_DATA_W;
   localparam int RATIO_W = $clog2(RATIO);

   // address widths seen by each port
   localparam int W_ADDR_W = ADDR_W - RATIO_W;
   localparam int R_ADDR_W = ADDR_W;

   // payload types
   typedef logic [W_DATA_W-1:0] w_data_t;
   typedef logic [R_DATA_W-1:0] r_data_t;

   // pointer and address types
   typedef logic [W_ADDR_W-1:0] w_addr_t;
   typedef logic [R_ADDR_W-1:0] r_addr_t;

   // one extra bit so a completely full FIFO can be reported
   typedef logic [ADDR_W:0] level_t;

   // capacity in bytes
   localparam level_t FIFO_SIZE = level_t'(1 << ADDR_W);

   // write domain status FSM
   typedef enum logic [1:0] {
      WR_INIT,
      WR_NORMAL,
      WR_FULL
   } wr_state_e;

   // read domain status FSM
   typedef enum logic [1:0] {
      RD_INIT,
      RD_EMPTY,
      RD_NORMAL
   } rd_state_e;

endpackage

/* common/cdc_pkg.sv */
package cdc_pkg;

   // flops in each pointer synchronizer
   localparam int SYNC_STAGES = 2;

   // widest pointer the conversion functions handle, narrower ones are zero extended
   localparam int PTR_MAX_W = 8;
   typedef logic [PTR_MAX_W-1:0] ptr_vec_t;

   function automatic ptr_vec_t bin_to_gray(input ptr_vec_t bin);
      return bin ^ (bin >> 1);
   endfunction

   // leading zeros from the extension leave the result unchanged
   function automatic ptr_vec_t gray_to_bin(input ptr_vec_t gray);
      ptr_vec_t bin;
      bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
      for (int i = PTR_MAX_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

/* common/ram_port_if.sv */
`timescale 1ns/1ns

interface ram_port_if;
   import afifo_pkg::*;

   // write side, one word per access
   logic    w_en;
   w_addr_t w_addr;
   w_data_t w_data;

   // read side, one byte per access
   logic    r_en;
   r_addr_t r_addr;
   r_data_t r_data;

   modport wr_ctrl (
      output w_en,
      output w_addr
   );

   modport rd_ctrl (
      output r_en,
      output r_addr,
      input  r_data
   );

   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

/* design/gray_sync.sv */
`timescale 1ns/1ns

module gray_sync #(
   parameter int DATA_W = 4
) (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic [DATA_W-1:0] gray_i,
   output logic [DATA_W-1:0] gray_o
);
   import cdc_pkg::*;

   // stage 0 may go metastable, later stages settle it
   logic [DATA_W-1:0] sync_q [SYNC_STAGES];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < SYNC_STAGES; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= gray_i;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // one bit changes per step, so the output is old or new, never a mix
   assign gray_o = sync_q[SYNC_STAGES-1];

endmodule

/* design/ram_t2p_asym.sv */
`timescale 1ns/1ns

module ram_t2p_asym (
   input  logic     w_clk_i,
   input  logic     r_clk_i,
   ram_port_if.mem  mem
);
   import afifo_pkg::*;

   localparam int DEPTH = 1 << W_ADDR_W;

   // word wide storage, 16 x 32
   w_data_t ram [DEPTH];

   // word select and byte lane from the read address
   w_addr_t            rd_word_addr;
   logic [RATIO_W-1:0] rd_lane;
   w_data_t            rd_word;
   r_data_t            rd_byte;

   always_ff @(posedge w_clk_i) begin
      if (mem.w_en) begin
         ram[mem.w_addr] <= mem.w_data;
      end
   end

   assign rd_word_addr = mem.r_addr[R_ADDR_W-1:RATIO_W];
   assign rd_lane      = mem.r_addr[RATIO_W-1:0];
   assign rd_word      = ram[rd_word_addr];

   // lane 0 is the least significant byte of the word
   assign rd_byte = rd_word[R_DATA_W*rd_lane +: R_DATA_W];

   // output holds until the next accepted read
   always_ff @(posedge r_clk_i) begin
      if (mem.r_en) begin
         mem.r_data <= rd_byte;
      end
   end

endmodule

/* ctrl/afifo_wr_ctrl.sv */
`timescale 1ns/1ns

module afifo_wr_ctrl (
   input  logic                w_clk_i,
   input  logic                arst_n_i,
   input  logic                w_en_i,
   input  afifo_pkg::r_addr_t  r_ptr_gray_sync_i,
   output afifo_pkg::w_addr_t  w_ptr_gray_o,
   output logic                w_full_o,
   output logic                w_empty_o,
   output afifo_pkg::level_t   w_level_o,
   ram_port_if.wr_ctrl         mem
);
   import afifo_pkg::*;
   import cdc_pkg::*;

   // local write pointer in words, binary and Gray
   w_addr_t w_ptr_bin_q;
   w_addr_t w_ptr_bin_nxt;
   w_addr_t w_ptr_gray_q;

   // read pointer as seen from this domain
   r_addr_t r_ptr_bin_sync;

   // both pointers in byte units
   r_addr_t w_ptr_byte;
   r_addr_t w_level_int;

   wr_state_e state_q;
   wr_state_e state_nxt;

   logic w_en_int;

   // write only lands when there is room for a full word
   assign w_en_int = w_en_i & ~w_full_o;

   assign w_ptr_bin_nxt = w_ptr_bin_q + w_addr_t'(1);

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_ptr_bin_q  <= '0;
         w_ptr_gray_q <= '0;
      end else if (w_en_int) begin
         w_ptr_bin_q  <= w_ptr_bin_nxt;
         w_ptr_gray_q <= w_addr_t'(bin_to_gray(ptr_vec_t'(w_ptr_bin_nxt)));
      end
   end

   assign w_ptr_gray_o = w_ptr_gray_q;

   assign r_ptr_bin_sync = r_addr_t'(gray_to_bin(ptr_vec_t'(r_ptr_gray_sync_i)));

   assign w_ptr_byte  = {w_ptr_bin_q, RATIO_W'(0)};
   assign w_level_int = w_ptr_byte - r_ptr_bin_sync;

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= WR_INIT;
      end else begin
         state_q <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state_q;
      w_full_o  = 1'b0;
      w_empty_o = 1'b0;
      w_level_o = level_t'(w_level_int);

      case (state_q)
         // both flags up for one cycle after reset
         WR_INIT: begin
            w_full_o  = 1'b1;
            w_empty_o = 1'b1;
            state_nxt = WR_NORMAL;
         end

         WR_NORMAL: begin
            if (w_level_int == '0) begin
               w_empty_o = 1'b1;
            end
            // less than a word of space once this write lands
            if (w_en_i && (level_t'(w_level_int) + level_t'(RATIO)) >
                          (FIFO_SIZE - level_t'(RATIO))) begin
               state_nxt = WR_FULL;
            end
         end

         WR_FULL: begin
            w_full_o = 1'b1;
            // pointers equal here means all 64 bytes are in use
            if (w_level_int == '0) begin
               w_level_o = FIFO_SIZE;
            end else if (level_t'(w_level_int) <= (FIFO_SIZE - level_t'(RATIO))) begin
               state_nxt = WR_NORMAL;
            end
         end

         default: begin
            state_nxt = WR_INIT;
         end
      endcase
   end

   assign mem.w_en   = w_en_int;
   assign mem.w_addr = w_ptr_bin_q;

endmodule

/* ctrl/afifo_rd_ctrl.sv */
`timescale 1ns/1ns

module afifo_rd_ctrl (
   input  logic                r_clk_i,
   input  logic                arst_n_i,
   input  logic                r_en_i,
   input  afifo_pkg::w_addr_t  w_ptr_gray_sync_i,
   output afifo_pkg::r_addr_t  r_ptr_gray_o,
   output logic                r_empty_o,
   output logic                r_full_o,
   output afifo_pkg::level_t   r_level_o,
   ram_port_if.rd_ctrl         mem
);
   import afifo_pkg::*;
   import cdc_pkg::*;

   // local read pointer in bytes, binary and Gray
   r_addr_t r_ptr_bin_q;
   r_addr_t r_ptr_bin_nxt;
   r_addr_t r_ptr_gray_q;

   // write pointer as seen from this domain
   w_addr_t w_ptr_bin_sync;
   r_addr_t w_ptr_byte_sync;

   r_addr_t r_level_int;

   rd_state_e state_q;
   rd_state_e state_nxt;

   logic r_en_int;

   // no read while the FIFO looks empty
   assign r_en_int = r_en_i & ~r_empty_o;

   assign r_ptr_bin_nxt = r_ptr_bin_q + r_addr_t'(1);

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_ptr_bin_q  <= '0;
         r_ptr_gray_q <= '0;
      end else if (r_en_int) begin
         r_ptr_bin_q  <= r_ptr_bin_nxt;
         r_ptr_gray_q <= r_addr_t'(bin_to_gray(ptr_vec_t'(r_ptr_bin_nxt)));
      end
   end

   assign r_ptr_gray_o = r_ptr_gray_q;

   assign w_ptr_bin_sync  = w_addr_t'(gray_to_bin(ptr_vec_t'(w_ptr_gray_sync_i)));
   assign w_ptr_byte_sync = {w_ptr_bin_sync, RATIO_W'(0)};

   // bytes available, possibly fewer than really written
   assign r_level_int = w_ptr_byte_sync - r_ptr_bin_q;

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= RD_INIT;
      end else begin
         state_q <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state_q;
      r_full_o  = 1'b0;
      r_empty_o = 1'b0;
      r_level_o = level_t'(r_level_int);

      case (state_q)
         // both flags up for one cycle after reset
         RD_INIT: begin
            r_full_o  = 1'b1;
            r_empty_o = 1'b1;
            state_nxt = RD_EMPTY;
         end

         RD_EMPTY: begin
            r_empty_o = 1'b1;
            if (r_level_int != '0) begin
               state_nxt = RD_NORMAL;
            end
         end

         RD_NORMAL: begin
            // this read takes the last byte
            if (r_en_i && r_level_int == r_addr_t'(1)) begin
               state_nxt = RD_EMPTY;
            end
            // zero difference outside the empty state is a full FIFO
            if (r_level_int == '0) begin
               r_full_o  = 1'b1;
               r_level_o = FIFO_SIZE;
            end
         end

         default: begin
            state_nxt = RD_INIT;
         end
      endcase
   end

   assign mem.r_en   = r_en_int;
   assign mem.r_addr = r_ptr_bin_q;

endmodule

/* design/afifo_top.sv */
`timescale 1ns/1ns

module afifo_top (
   input  logic                arst_n_i,

   // write port
   input  logic                w_clk_i,
   input  logic                w_en_i,
   input  afifo_pkg::w_data_t  w_data_i,
   output logic                w_full_o,
   output logic                w_empty_o,
   output afifo_pkg::level_t   w_level_o,

   // read port
   input  logic                r_clk_i,
   input  logic                r_en_i,
   output afifo_pkg::r_data_t  r_data_o,
   output logic                r_empty_o,
   output logic                r_full_o,
   output afifo_pkg::level_t   r_level_o
);
   import afifo_pkg::*;

   ram_port_if ram_if ();

   // Gray pointers, local and synchronized copies
   w_addr_t w_ptr_gray;
   w_addr_t w_ptr_gray_sync;
   r_addr_t r_ptr_gray;
   r_addr_t r_ptr_gray_sync;

   assign ram_if.w_data = w_data_i;
   assign r_data_o      = ram_if.r_data;

   afifo_wr_ctrl i_wr_ctrl (
      .w_clk_i           (w_clk_i),
      .arst_n_i          (arst_n_i),
      .w_en_i            (w_en_i),
      .r_ptr_gray_sync_i (r_ptr_gray_sync),
      .w_ptr_gray_o      (w_ptr_gray),
      .w_full_o          (w_full_o),
      .w_empty_o         (w_empty_o),
      .w_level_o         (w_level_o),
      .mem               (ram_if.wr_ctrl)
   );

   afifo_rd_ctrl i_rd_ctrl (
      .r_clk_i           (r_clk_i),
      .arst_n_i          (arst_n_i),
      .r_en_i            (r_en_i),
      .w_ptr_gray_sync_i (w_ptr_gray_sync),
      .r_ptr_gray_o      (r_ptr_gray),
      .r_empty_o         (r_empty_o),
      .r_full_o          (r_full_o),
      .r_level_o         (r_level_o),
      .mem               (ram_if.rd_ctrl)
   );

   // write pointer into the read clock domain
   gray_sync #(.DATA_W(W_ADDR_W)) i_w_ptr_sync (
      .clk_i    (r_clk_i),
      .arst_n_i (arst_n_i),
      .gray_i   (w_ptr_gray),
      .gray_o   (w_ptr_gray_sync)
   );

   // read pointer into the write clock domain
   gray_sync #(.DATA_W(R_ADDR_W)) i_r_ptr_sync (
      .clk_i    (w_clk_i),
      .arst_n_i (arst_n_i),
      .gray_i   (r_ptr_gray),
      .gray_o   (r_ptr_gray_sync)
   );

   ram_t2p_asym i_ram (
      .w_clk_i (w_clk_i),
      .r_clk_i (r_clk_i),
      .mem     (ram_if.mem)
   );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int PERIOD_NS = 40,
   parameter int OFFSET_NS = 0
) (
   output logic clk_o
);

   // low for the offset, then a free running square wave
   initial begin
      clk_o = 1'b0;
      #(OFFSET_NS);
      forever begin
         #(PERIOD_NS / 2);
         clk_o = ~clk_o;
      end
   end

endmodule

/* verif/tb_afifo.sv */
`timescale 1ns/1ns

module tb_afifo;
   import afifo_pkg::*;

   // about 500 cycles of traffic, the run is cut off well past that
   localparam int TEST_CYCLES    = 500;
   localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
   localparam int CAPACITY       = 1 << ADDR_W;

   logic    w_clk;
   logic    r_clk;
   logic    arst_n_i;
   logic    w_en_i;
   w_data_t w_data_i;
   logic    w_full_o;
   logic    w_empty_o;
   level_t  w_level_o;
   logic    r_en_i;
   r_data_t r_data_o;
   logic    r_empty_o;
   logic    r_full_o;
   level_t  r_level_o;

   // bytes in the order the read port must deliver them
   r_data_t model_q[$];
   r_data_t last_byte;

   integer seed;
   int     cycle_cnt;
   int     words_written;
   int     bytes_read;
   int     mismatch_cnt;
   int     error_cnt;
   bit     wr_done;
   bit     rd_done;

   tb_clk_gen #(.PERIOD_NS(40), .OFFSET_NS(0)) i_w_clk_gen (.clk_o(w_clk));
   // read clock trails by 13 ns so the edges never line up
   tb_clk_gen #(.PERIOD_NS(40), .OFFSET_NS(13)) i_r_clk_gen (.clk_o(r_clk));

   afifo_top i_afifo_top (
      .arst_n_i  (arst_n_i),
      .w_clk_i   (w_clk),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .w_empty_o (w_empty_o),
      .w_level_o (w_level_o),
      .r_clk_i   (r_clk),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .r_full_o  (r_full_o),
      .r_level_o (r_level_o)
   );

   task automatic note_mismatch(input string msg);
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s", $time, msg);
   endtask

   task automatic note_error(input string msg);
      error_cnt++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   // the write side can only overestimate, its view of the read pointer is old
   task automatic write_side_checks();
      assert (int'(w_level_o) >= model_q.size())
         else note_mismatch($sformatf("w_level_o %0d below model count %0d",
                                      w_level_o, model_q.size()));
      if (w_empty_o && !w_full_o) begin
         assert (w_level_o == '0)
            else note_mismatch($sformatf("w_empty_o high with w_level_o %0d", w_level_o));
      end
   endtask

   task automatic read_side_checks();
      assert (int'(r_level_o) <= model_q.size())
         else note_mismatch($sformatf("r_level_o %0d above model count %0d",
                                      r_level_o, model_q.size()));
      if (r_full_o && !r_empty_o) begin
         assert (int'(r_level_o) == CAPACITY)
            else note_mismatch($sformatf("r_full_o high with r_level_o %0d", r_level_o));
      end
   endtask

   // called 2 ns after a write clock edge, returns 2 ns after the next one
   task automatic write_cycle(input logic en, input w_data_t data);
      logic take;
      int   i;
      w_en_i   = en;
      w_data_i = data;
      take     = en & ~w_full_o;
      @(posedge w_clk);
      #2;
      w_en_i = 1'b0;
      if (take) begin
         words_written++;
         // least significant byte leaves first
         for (i = 0; i < RATIO; i++) begin
            model_q.push_back(r_data_t'(data >> (i * R_DATA_W)));
         end
      end
      write_side_checks();
   endtask

   task automatic read_cycle(input logic en);
      logic    take;
      r_data_t exp;
      r_en_i = en;
      take   = en & ~r_empty_o;
      @(posedge r_clk);
      #2;
      r_en_i = 1'b0;
      if (take) begin
         if (model_q.size() == 0) begin
            note_error("a read was accepted while the model holds no data");
         end else begin
            exp = model_q.pop_front();
            bytes_read++;
            assert (r_data_o == exp)
               else note_mismatch($sformatf("byte %0d expected %02h got %02h",
                                            bytes_read, exp, r_data_o));
            last_byte = exp;
         end
      end
      read_side_checks();
   endtask

   task automatic fill_writes();
      int n;
      bit seen_full;
      seen_full = 1'b0;
      for (n = 0; n < 24; n++) begin
         write_cycle(1'b1, w_data_t'($random(seed)));
         if (w_full_o) begin
            if (!seen_full) begin
               assert (model_q.size() == CAPACITY)
                  else note_mismatch($sformatf("w_full_o rose after %0d words",
                                               model_q.size() / RATIO));
            end
            assert (int'(w_level_o) == CAPACITY)
               else note_mismatch($sformatf("full with w_level_o %0d", w_level_o));
            seen_full = 1'b1;
         end
      end
      assert (seen_full) else note_error("w_full_o never rose while filling");
   endtask

   // strict mode expects r_empty_o to rise only once the model is empty
   task automatic drain_reads(input bit strict);
      logic was_empty;
      was_empty = r_empty_o;
      while (!(r_empty_o && model_q.size() == 0)) begin
         read_cycle(1'b1);
         if (strict && r_empty_o && !was_empty) begin
            assert (model_q.size() == 0)
               else note_mismatch($sformatf("r_empty_o rose with %0d bytes left",
                                            model_q.size()));
         end
         was_empty = r_empty_o;
      end
   endtask

   // enable probabilities are rate/8
   task automatic random_writes(input int cycles, input int rate);
      int n;
      for (n = 0; n < cycles; n++) begin
         write_cycle(($random(seed) & 7) < rate, w_data_t'($random(seed)));
      end
   endtask

   task automatic random_reads(input int cycles, input int rate);
      int n;
      for (n = 0; n < cycles; n++) begin
         read_cycle(($random(seed) & 7) < rate);
      end
   endtask

   always @(posedge w_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("ERROR: timeout, the test did not finish in %0d cycles", TIMEOUT_CYCLES);
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      seed          = 29;
      cycle_cnt     = 0;
      words_written = 0;
      bytes_read    = 0;
      mismatch_cnt  = 0;
      error_cnt     = 0;
      wr_done       = 1'b0;
      rd_done       = 1'b0;
      last_byte     = '0;
      arst_n_i      = 1'b0;
      w_en_i        = 1'b0;
      w_data_i      = '0;
      r_en_i        = 1'b0;
      repeat (5) @(posedge w_clk);
      #2;
      arst_n_i = 1'b1;

      // one cycle out of reset, both sides idle and empty
      fork
         begin
            @(posedge w_clk);
            #2;
            assert (w_empty_o && !w_full_o && w_level_o == '0)
               else note_mismatch("write side flags or level wrong after reset");
         end
         begin
            @(posedge r_clk);
            #2;
            assert (r_empty_o && !r_full_o && r_level_o == '0)
               else note_mismatch("read side flags or level wrong after reset");
         end
      join

      // fill with writes only, then keep pushing while full
      fork
         begin
            @(posedge w_clk);
            #2;
            fill_writes();
            wr_done = 1'b1;
         end
         begin
            @(posedge r_clk);
            #2;
            while (!wr_done) read_cycle(1'b0);
         end
      join

      // drain with reads only, then read on while empty
      fork
         begin
            @(posedge w_clk);
            #2;
            while (!rd_done) write_cycle(1'b0, '0);
            assert (w_empty_o && w_level_o == '0)
               else note_mismatch("write side not empty after the drain");
         end
         begin
            @(posedge r_clk);
            #2;
            drain_reads(1'b1);
            repeat (6) begin
               read_cycle(1'b1);
               assert (r_empty_o && r_data_o == last_byte)
                  else note_mismatch("read while empty changed the flag or the data");
            end
            rd_done = 1'b1;
         end
      join

      // mixed traffic, first pushing toward full, then toward empty
      fork
         begin
            @(posedge w_clk);
            #2;
            random_writes(150, 3);
            random_writes(150, 1);
         end
         begin
            @(posedge r_clk);
            #2;
            random_reads(300, 7);
         end
      join

      rd_done = 1'b0;
      fork
         begin
            @(posedge w_clk);
            #2;
            while (!rd_done) write_cycle(1'b0, '0);
         end
         begin
            @(posedge r_clk);
            #2;
            drain_reads(1'b0);
            rd_done = 1'b1;
         end
      join

      $display("summary: words written %0d, bytes read %0d, mismatches %0d, other errors %0d",
               words_written, bytes_read, mismatch_cnt, error_cnt);
      if (mismatch_cnt == 0 && error_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* afifo.f */
common/afifo_pkg.sv
common/cdc_pkg.sv
common/ram_port_if.sv
design/gray_sync.sv
design/ram_t2p_asym.sv
ctrl/afifo_wr_ctrl.sv
ctrl/afifo_rd_ctrl.sv
design/afifo_top.sv
verif/tb_clk_gen.sv
verif/tb_afifo.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f afifo.f \
   --top-module tb_afifo \
   --Mdir obj_dir \
   -o tb_afifo

./obj_dir/tb_afifo > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi

echo "simulation passed"
exit 0
